/* filelist.f */
+incdir+common
common/lsu_pkg.sv
common/dmem_if.sv
dmem/dmem_ctrl_regs.sv
dmem/dmem_slave.sv
lsu/lsu_core.sv
hw/lsu_subsys_top.sv
testbench/tb_lsu_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lsu_subsys
RTL_TOP   ?= lsu_subsys_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_lsu_subsys.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module tb_lsu_subsys import lsu_pkg::*; ();

    typedef struct {
        string       name;
        logic        st;       // store when set and load when clear
        mem_op_e     op;
        logic [31:0] a;
        logic        inv;
        int          hold;     // cycles in_ready stays low after out_valid
        logic        cfg_en;
        logic [1:0]  cfg_a;
        logic [31:0] cfg_d;
    } test_t;

    logic clk, rst, in_valid, in_ready, is_load, is_store, inst_invalid, cfg_wen;
    logic out_ready, out_valid, store_enable, resp_err;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] store_data, load_data, cfg_wdata;
    logic [1:0]             cfg_addr;
    mem_op_e                funct3;

    test_t       tests[$];
    data_word_u  shadow [1<<`DMEM_WORDS_LOG2];
    logic [31:0] win_base, win_limit;  // fault window as the tb last wrote it
    int          errors, tests_run;
    logic        timed_out;

    lsu_subsys_top dut (
        .clk(clk), .rst(rst), .addr(addr), .store_data(store_data), .funct3(funct3),
        .is_load(is_load), .is_store(is_store), .inst_invalid(inst_invalid),
        .in_valid(in_valid), .out_ready(out_ready), .load_data(load_data),
        .store_enable(store_enable), .out_valid(out_valid), .in_ready(in_ready),
        .resp_err(resp_err), .cfg_wen(cfg_wen), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_word(input string name, input data_word_u exp, input data_word_u act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    // byte and halfword stores replace only their own lane
    function automatic data_word_u merge_store(data_word_u old, mem_op_e op, logic [1:0] off,
                                               logic [31:0] d);
        data_word_u w;
        w = old;
        case (op)
            SB:      w.bytes[off] = d[7:0];
            SH:      w.halves[off[1]] = d[15:0];
            default: w = d;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] expect_load(data_word_u w, mem_op_e op, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w.bytes[off];
        h = w.halves[off[1]];
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'b0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'b0, h};
            default: return w;
        endcase
    endfunction

    function automatic logic in_window(logic [31:0] a);
        return (a >= win_base) && (a < win_limit);
    endfunction

    task automatic add_test(input string name, input logic st, input mem_op_e op,
                            input logic [31:0] a, input logic inv, input int hold,
                            input logic cfg_en, input logic [1:0] cfg_a, input logic [31:0] cfg_d);
        test_t t;
        t = '{name, st, op, a, inv, hold, cfg_en, cfg_a, cfg_d};
        tests.push_back(t);
    endtask

    task automatic write_cfg(input logic [1:0] a, input logic [31:0] d);
        @(posedge clk);
        cfg_wen   <= 1'b1;
        cfg_addr  <= a;
        cfg_wdata <= d;
        @(posedge clk);
        cfg_wen <= 1'b0;
        if (a == 2'd2) win_base = d;
        else if (a == 2'd3) win_limit = d;
    endtask

    task automatic run_test(input test_t t);
        int          cyc;
        int          err_before;
        int          idx;
        logic [31:0] data;
        logic        exp_err;
        logic        fault;
        data_word_u  held_data;
        logic        held_err, held_se;
        err_before = errors;
        data = $urandom;
        if (t.st && t.op != SW)
            data = data | 32'h0000_8080; // negative byte and halfword values
        idx = int'(t.a[`DMEM_WORDS_LOG2+1:2]);
        if (t.cfg_en)
            write_cfg(t.cfg_a, t.cfg_d);
        fault = in_window(t.a);
        exp_err = fault && !t.inv; // invalid stores never reach the bus
        @(posedge clk);
        addr <= t.a;
        store_data <= data;
        funct3 <= t.op;
        is_load <= !t.st;
        is_store <= t.st;
        inst_invalid <= t.inv;
        in_valid <= 1'b1;
        in_ready <= (t.hold == 0);
        cyc = 0;
        @(negedge clk);
        while (!out_ready && cyc < 50) begin
            @(negedge clk);
            cyc++;
        end
        if (!out_ready) begin
            $display("test %s: request was never accepted", t.name);
            errors++;
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        cyc = 0;
        @(negedge clk);
        while (!out_valid && cyc < 100) begin
            @(negedge clk);
            cyc++;
        end
        if (!out_valid) begin
            $display("test %s: timed out waiting for out_valid", t.name);
            errors++;
            timed_out = 1'b1;
            return;
        end
        check_flag({t.name, " resp_err"}, exp_err, resp_err);
        if (t.st) begin
            check_flag({t.name, " store_enable"}, !t.inv, store_enable);
            if (!t.inv && !fault)
                shadow[idx] = merge_store(shadow[idx], t.op, t.a[1:0], data);
        end else begin
            check_flag({t.name, " store_enable"}, 1'b0, store_enable);
            check_word({t.name, " load_data"},
                       exp_err ? 32'h0 : expect_load(shadow[idx], t.op, t.a[1:0]), load_data);
        end
        held_data = load_data;
        held_err = resp_err;
        held_se = store_enable;
        for (int i = 0; i < t.hold; i++) begin
            @(negedge clk);
            check_flag({t.name, " out_valid held"}, 1'b1, out_valid);
            check_flag({t.name, " resp_err held"}, held_err, resp_err);
            check_flag({t.name, " store_enable held"}, held_se, store_enable);
            check_word({t.name, " load_data held"}, held_data, load_data);
        end
        if (t.hold > 0) begin
            @(posedge clk);
            in_ready <= 1'b1; // result leaves on the next edge
        end
        tests_run++;
        $display("test %-16s %s", t.name, (errors == err_before) ? "passed" : "failed");
    endtask

    initial begin
        void'($urandom(18463));
        rst = 1'b1;
        in_valid = 1'b0;
        in_ready = 1'b0;
        addr = '0;
        store_data = '0;
        funct3 = LW;
        is_load = 1'b0;
        is_store = 1'b0;
        inst_invalid = 1'b0;
        cfg_wen = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        errors = 0;
        tests_run = 0;
        timed_out = 1'b0;
        win_base = '0;
        win_limit = '0;

        add_test("sw_base",        1'b1, SW,  32'h000, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lw_base",        1'b0, LW,  32'h000, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("sw_inv",         1'b1, SW,  32'h000, 1'b1, 0, 1'b0, 2'd0, 32'h0);
        add_test("lw_after_inv",   1'b0, LW,  32'h000, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("sw_w1",          1'b1, SW,  32'h040, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("sb_off0",        1'b1, SB,  32'h040, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("sb_off1",        1'b1, SB,  32'h041, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("sb_off2",        1'b1, SB,  32'h042, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("sb_off3",        1'b1, SB,  32'h043, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lb_off1",        1'b0, LB,  32'h041, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lbu_off1",       1'b0, LBU, 32'h041, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lb_off2",        1'b0, LB,  32'h042, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lbu_off3",       1'b0, LBU, 32'h043, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lw_w1",          1'b0, LW,  32'h040, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("sw_w2",          1'b1, SW,  32'h044, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("sh_off0",        1'b1, SH,  32'h044, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("sh_off2",        1'b1, SH,  32'h046, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lh_off2",        1'b0, LH,  32'h046, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lhu_off2",       1'b0, LHU, 32'h046, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lh_off0",        1'b0, LH,  32'h044, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lhu_off0",       1'b0, LHU, 32'h044, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        // fault window [0x100, 0x120) opened and later closed again
        add_test("sw_pre_fault",   1'b1, SW,  32'h104, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lw_fault_base",  1'b0, LW,  32'h040, 1'b0, 0, 1'b1, 2'd2, 32'h100);
        add_test("lw_fault_in",    1'b0, LW,  32'h104, 1'b0, 0, 1'b1, 2'd3, 32'h120);
        add_test("sw_fault_in",    1'b1, SW,  32'h104, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lw_fault_out",   1'b0, LW,  32'h044, 1'b0, 0, 1'b0, 2'd0, 32'h0);
        add_test("lw_fault_closed", 1'b0, LW, 32'h104, 1'b0, 0, 1'b1, 2'd3, 32'h100);
        // wait states with back-pressure
        add_test("lw_rd_wait",     1'b0, LW,  32'h040, 1'b0, 6, 1'b1, 2'd0, 32'd5);
        add_test("sw_wr_wait",     1'b1, SW,  32'h048, 1'b0, 3, 1'b1, 2'd1, 32'd4);
        add_test("lw_wr_wait",     1'b0, LW,  32'h048, 1'b0, 5, 1'b0, 2'd0, 32'h0);
        add_test("lb_wait",        1'b0, LB,  32'h047, 1'b0, 2, 1'b0, 2'd0, 32'h0);
        add_test("lw_fault_hold",  1'b0, LW,  32'h108, 1'b0, 4, 1'b1, 2'd3, 32'h120);

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("reset out_valid", 1'b0, out_valid);
        check_flag("reset resp_err", 1'b0, resp_err);
        check_flag("reset store_enable", 1'b0, store_enable);
        check_flag("reset out_ready", 1'b1, out_ready);
        tests_run++;
        $display("test %-16s %s", "reset_state", (errors == 0) ? "passed" : "failed");

        for (int i = 0; i < tests.size() && !timed_out; i++)
            run_test(tests[i]);

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* hw/lsu_subsys_top.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_subsys_top import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`LSU_ADDR_W-1:0]  addr,
    input  logic [`LSU_DATA_W-1:0]  store_data,
    input  mem_op_e                 funct3,
    input  logic                    is_load,
    input  logic                    is_store,
    input  logic                    inst_invalid,
    input  logic                    in_valid,
    output logic                    out_ready,
    output logic [`LSU_DATA_W-1:0]  load_data,
    output logic                    store_enable,
    output logic                    out_valid,
    input  logic                    in_ready,
    output logic                    resp_err,
    // config strobe port
    input  logic                    cfg_wen,
    input  logic [1:0]              cfg_addr,
    input  logic [`LSU_DATA_W-1:0]  cfg_wdata
);

    logic [`DMEM_WAIT_W-1:0] rd_wait;
    logic [`DMEM_WAIT_W-1:0] wr_wait;
    logic [`LSU_ADDR_W-1:0]  fault_base;
    logic [`LSU_ADDR_W-1:0]  fault_limit;

    dmem_if bus_if ();

    lsu_core u_lsu_core (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .store_data   (store_data),
        .funct3       (funct3),
        .is_load      (is_load),
        .is_store     (is_store),
        .inst_invalid (inst_invalid),
        .in_valid     (in_valid),
        .out_ready    (out_ready),
        .load_data    (load_data),
        .store_enable (store_enable),
        .out_valid    (out_valid),
        .in_ready     (in_ready),
        .resp_err     (resp_err),
        .bus          (bus_if.master)
    );

    dmem_ctrl_regs u_ctrl_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_wen     (cfg_wen),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .rd_wait     (rd_wait),
        .wr_wait     (wr_wait),
        .fault_base  (fault_base),
        .fault_limit (fault_limit)
    );

    dmem_slave u_dmem_slave (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus_if.slave),
        .rd_wait     (rd_wait),
        .wr_wait     (wr_wait),
        .fault_base  (fault_base),
        .fault_limit (fault_limit)
    );

endmodule

/* lsu/lsu_core.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_core import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // from execute
    input  logic [`LSU_ADDR_W-1:0]  addr,
    input  logic [`LSU_DATA_W-1:0]  store_data,
    input  mem_op_e                 funct3,
    input  logic                    is_load,
    input  logic                    is_store,
    input  logic                    inst_invalid,
    input  logic                    in_valid,
    output logic                    out_ready,
    // to writeback
    output logic [`LSU_DATA_W-1:0]  load_data,
    output logic                    store_enable,
    output logic                    out_valid,
    input  logic                    in_ready,
    output logic                    resp_err,
    dmem_if.master                  bus
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_AR,
        S_R,
        S_AW,
        S_W,
        S_B,
        S_DONE
    } state_e;

    state_e                  state;
    logic [`LSU_ADDR_W-1:0]  addr_q;
    logic [`LSU_DATA_W-1:0]  sdata_q;
    mem_op_e                 op_q;
    logic                    load_q;
    logic                    store_q;
    logic                    invalid_q;
    data_word_u              rdata_q;
    resp_e                   resp_q;

    logic       in_fire;
    logic       out_fire;
    logic       req_ok;
    logic [1:0] off;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [`LSU_DATA_W-1:0] ext_data;

    // first state for a freshly accepted request
    function automatic state_e start_state(input logic ld, input logic inv);
        state_e s;
        if (inv)
            s = S_DONE; // no bus traffic
        else if (ld)
            s = S_AR;
        else
            s = S_AW;
        return s;
    endfunction

    assign out_ready = (state == S_IDLE) || (state == S_DONE && in_ready);
    assign out_valid = (state == S_DONE);
    assign in_fire   = in_valid && out_ready;
    assign out_fire  = out_valid && in_ready;
    assign req_ok    = in_fire && (is_load || is_store);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (req_ok) state <= start_state(is_load, inst_invalid);
                S_AR:   if (bus.arready) state <= S_R;
                S_R:    if (bus.rvalid) state <= S_DONE;
                S_AW:   if (bus.awready) state <= S_W;
                S_W:    if (bus.wready) state <= S_B;
                S_B:    if (bus.bvalid) state <= S_DONE;
                S_DONE: begin
                    if (req_ok)
                        state <= start_state(is_load, inst_invalid);
                    else if (out_fire)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // request latch
    always_ff @(posedge clk) begin
        if (rst) begin
            load_q    <= 1'b0;
            store_q   <= 1'b0;
            invalid_q <= 1'b0;
        end else if (req_ok) begin
            load_q    <= is_load;
            store_q   <= is_store && !is_load;
            invalid_q <= inst_invalid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_ok) begin
            addr_q  <= addr;
            sdata_q <= store_data;
            op_q    <= funct3;
        end
        if (bus.rvalid && bus.rready)
            rdata_q <= bus.rdata;
    end

    always_ff @(posedge clk) begin
        if (rst)
            resp_q <= OKAY;
        else if (req_ok)
            resp_q <= OKAY;
        else if (bus.rvalid && bus.rready)
            resp_q <= bus.rresp;
        else if (bus.bvalid && bus.bready)
            resp_q <= bus.bresp;
    end

    assign off = addr_q[1:0];

    assign bus.arvalid = (state == S_AR);
    assign bus.araddr  = addr_q;
    assign bus.rready  = (state == S_R);
    assign bus.awvalid = (state == S_AW);
    assign bus.awaddr  = addr_q;
    assign bus.wvalid  = (state == S_W);
    assign bus.bready  = (state == S_B);

    // narrow stores are copied to every lane and wstrb picks the lane
    always_comb begin
        case (op_q)
            SB: begin
                bus.wdata = {4{sdata_q[7:0]}};
                bus.wstrb = 4'b0001 << off;
            end
            SH: begin
                bus.wdata = {2{sdata_q[15:0]}};
                bus.wstrb = 4'b0011 << {off[1], 1'b0};
            end
            SW: begin
                bus.wdata = sdata_q;
                bus.wstrb = 4'b1111;
            end
            default: begin
                bus.wdata = sdata_q;
                bus.wstrb = 4'b0000;
            end
        endcase
    end

    assign byte_sel = rdata_q.bytes[off];
    assign half_sel = rdata_q.halves[off[1]];

    always_comb begin
        case (op_q)
            LB:      ext_data = {{24{byte_sel[7]}}, byte_sel};
            LH:      ext_data = {{16{half_sel[15]}}, half_sel};
            LW:      ext_data = rdata_q;
            LBU:     ext_data = {24'b0, byte_sel};
            LHU:     ext_data = {16'b0, half_sel};
            default: ext_data = '0;
        endcase
    end

    assign load_data    = (out_valid && load_q && !invalid_q) ? ext_data : '0;
    assign store_enable = out_valid && store_q && !invalid_q;
    assign resp_err     = out_valid && (resp_q != OKAY);

endmodule

/* dmem/dmem_slave.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module dmem_slave import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    dmem_if.slave                   bus,
    input  logic [`DMEM_WAIT_W-1:0] rd_wait,
    input  logic [`DMEM_WAIT_W-1:0] wr_wait,
    input  logic [`LSU_ADDR_W-1:0]  fault_base,
    input  logic [`LSU_ADDR_W-1:0]  fault_limit
);

    typedef enum logic [1:0] {
        SL_IDLE,
        SL_RD,
        SL_WR,
        SL_BRESP
    } sl_state_e;

    sl_state_e                    state;
    logic [`DMEM_WAIT_W-1:0]      wait_cnt;
    logic                         fault_q;
    logic [`LSU_ADDR_W-1:0]       addr_q;
    logic [`LSU_ADDR_W-1:0]       req_addr;
    logic                         in_fault;
    logic [`DMEM_WORDS_LOG2-1:0]  idx;
    data_word_u                   merged;
    data_word_u                   mem [1<<`DMEM_WORDS_LOG2];

    assign req_addr = bus.arvalid ? bus.araddr : bus.awaddr;  // reads win
    assign in_fault = (req_addr >= fault_base) && (req_addr < fault_limit);
    assign idx      = addr_q[`DMEM_WORDS_LOG2+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SL_IDLE;
            wait_cnt <= '0;
            fault_q  <= 1'b0;
        end else begin
            case (state)
                SL_IDLE: begin
                    if (bus.arvalid) begin
                        state    <= SL_RD;
                        wait_cnt <= rd_wait;
                        fault_q  <= in_fault;
                    end else if (bus.awvalid) begin
                        state    <= SL_WR;
                        wait_cnt <= wr_wait;
                        fault_q  <= in_fault;
                    end
                end
                SL_RD: begin
                    if (wait_cnt != '0) wait_cnt <= wait_cnt - 1'b1;
                    else if (bus.rready) state <= SL_IDLE;
                end
                SL_WR: begin
                    if (wait_cnt != '0) wait_cnt <= wait_cnt - 1'b1;
                    else if (bus.wvalid) state <= SL_BRESP;
                end
                SL_BRESP: if (bus.bready) state <= SL_IDLE;
                default: state <= SL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SL_IDLE && (bus.arvalid || bus.awvalid))
            addr_q <= req_addr;
    end

    // byte-strobe merge into the addressed word
    always_comb begin
        merged = mem[idx];
        for (int i = 0; i < `LSU_DATA_W/8; i++) begin
            if (bus.wstrb[i]) merged.bytes[i] = bus.wdata[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (bus.wvalid && bus.wready && !fault_q)
            mem[idx] <= merged;
    end

    assign bus.arready = (state == SL_IDLE);
    assign bus.awready = (state == SL_IDLE) && !bus.arvalid;
    assign bus.rvalid  = (state == SL_RD) && (wait_cnt == '0);
    assign bus.rdata   = fault_q ? '0 : mem[idx];
    assign bus.rresp   = fault_q ? SLVERR : OKAY;
    assign bus.wready  = (state == SL_WR) && (wait_cnt == '0);
    assign bus.bvalid  = (state == SL_BRESP);
    assign bus.bresp   = fault_q ? SLVERR : OKAY;

endmodule

/* dmem/dmem_ctrl_regs.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module dmem_ctrl_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfg_wen,
    input  logic [1:0]              cfg_addr,
    input  logic [`LSU_DATA_W-1:0]  cfg_wdata,
    output logic [`DMEM_WAIT_W-1:0] rd_wait,
    output logic [`DMEM_WAIT_W-1:0] wr_wait,
    output logic [`LSU_ADDR_W-1:0]  fault_base,
    output logic [`LSU_ADDR_W-1:0]  fault_limit
);

    // base == limit means no fault window
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_wait     <= `DMEM_WAIT_W'(`DMEM_RD_WAIT_RST);
            wr_wait     <= `DMEM_WAIT_W'(`DMEM_WR_WAIT_RST);
            fault_base  <= '0;
            fault_limit <= '0;
        end else if (cfg_wen) begin
            case (cfg_addr)
                2'd0: rd_wait     <= cfg_wdata[`DMEM_WAIT_W-1:0];
                2'd1: wr_wait     <= cfg_wdata[`DMEM_WAIT_W-1:0];
                2'd2: fault_base  <= cfg_wdata[`LSU_ADDR_W-1:0];
                2'd3: fault_limit <= cfg_wdata[`LSU_ADDR_W-1:0];
                default: ;
            endcase
        end
    end

endmodule

/* common/dmem_if.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

interface dmem_if import lsu_pkg::*; ();

    logic                       arvalid;
    logic                       arready;
    logic [`LSU_ADDR_W-1:0]     araddr;
    logic                       rvalid;
    logic                       rready;
    logic [`LSU_DATA_W-1:0]     rdata;
    resp_e                      rresp;

    logic                       awvalid;
    logic                       awready;
    logic [`LSU_ADDR_W-1:0]     awaddr;
    logic                       wvalid;
    logic                       wready;
    logic [`LSU_DATA_W-1:0]     wdata;
    logic [`LSU_DATA_W/8-1:0]   wstrb;
    logic                       bvalid;
    logic                       bready;
    resp_e                      bresp;

    modport master (
        output arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
        input  arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
    );

    modport slave (
        input  arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
        output arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
    );

endinterface

/* common/lsu_pkg.sv */
`include "lsu_config.svh"

package lsu_pkg;

    // funct3 codes of the RV32 loads
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } mem_op_e;

    // stores reuse the load codes
    localparam mem_op_e SB = LB;
    localparam mem_op_e SH = LH;
    localparam mem_op_e SW = LW;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // one data word, by byte lane or by halfword
    typedef union packed {
        logic [`LSU_DATA_W/8-1:0][7:0]   bytes;
        logic [`LSU_DATA_W/16-1:0][15:0] halves;
    } data_word_u;

endpackage

/* common/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// memory depth in words, as log2
`define DMEM_WORDS_LOG2 8

`define DMEM_WAIT_W      8  // wait counter width
`define DMEM_RD_WAIT_RST 1
`define DMEM_WR_WAIT_RST 1

`endif
